// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address of the first fetch after reset
`define FETCH_RESET_VECTOR 32'h0000_0200

// Number of one-word instruction cache lines, must be a power of two
`define FETCH_ICACHE_LINES 16

`endif

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

	// One instruction word seen in two ways
	typedef union packed {
		// Register view, used for all four register indices
		struct packed {
			logic [4:0] rs3;
			logic [1:0] format;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		// System view, funct12 selects ECALL, MRET and WFI
		struct packed {
			logic [11:0] funct12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} sys;
	} rv_instr_u;

	// Major opcodes
	parameter logic [6:0] OPC_LOAD     = 7'b0000011;
	parameter logic [6:0] OPC_STORE    = 7'b0100011;
	parameter logic [6:0] OPC_OP       = 7'b0110011;
	parameter logic [6:0] OPC_OP_IMM   = 7'b0010011;
	parameter logic [6:0] OPC_LUI      = 7'b0110111;
	parameter logic [6:0] OPC_AUIPC    = 7'b0010111;
	parameter logic [6:0] OPC_JAL      = 7'b1101111;
	parameter logic [6:0] OPC_JALR     = 7'b1100111;
	parameter logic [6:0] OPC_BRANCH   = 7'b1100011;
	parameter logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// Floating-point opcodes
	parameter logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	parameter logic [6:0] OPC_STORE_FP = 7'b0100111;
	parameter logic [6:0] OPC_OP_FP    = 7'b1010011;
	parameter logic [6:0] OPC_FMADD    = 7'b1000011;

	// funct12 of the privileged SYSTEM words (funct3 is zero for all)
	parameter logic [11:0] F12_ECALL = 12'h000;
	parameter logic [11:0] F12_MRET  = 12'h302;
	parameter logic [11:0] F12_WFI   = 12'h105;

endpackage

// File: src/fetch_pkg.sv
package fetch_pkg;

	// Bank bit on top of the 5-bit register number
	parameter int REG_INDEX_W = 6;

	// Packet tag, increments once per delivered word
	parameter int FETCH_TAG_W = 32;

	// Sequencer states
	parameter logic ST_WAIT_CACHE = 1'b0;
	parameter logic ST_WAIT_JUMP  = 1'b1;

endpackage

// File: src/instr_cache.sv
`timescale 1ns/1ps

`include "fetch_params.svh"

module instr_cache (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [31:0] i_pc,
	input  logic        i_stall,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output logic        o_bus_request,
	output logic [31:0] o_bus_address
);

	localparam int INDEX_W = $clog2(`FETCH_ICACHE_LINES);
	localparam int TAG_W = 30 - INDEX_W;

	logic [`FETCH_ICACHE_LINES-1:0] line_valid;
	logic [TAG_W-1:0] line_tag [`FETCH_ICACHE_LINES];
	logic [31:0] line_data [`FETCH_ICACHE_LINES];

	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] lookup_tag;
	logic lookup_hit;
	logic [INDEX_W-1:0] refill_index;
	logic [TAG_W-1:0] refill_tag;

	logic ready_q;
	logic [31:0] rdata_q;
	logic [31:0] ready_pc_q;
	logic request_q;
	logic [31:0] address_q;
	logic delivered;

	assign lookup_index = i_pc[INDEX_W+1:2];
	assign lookup_tag = i_pc[31:INDEX_W+2];
	assign lookup_hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
	assign refill_index = address_q[INDEX_W+1:2];
	assign refill_tag = address_q[31:INDEX_W+2];

	// A word only counts if the PC still points at it
	assign delivered = ready_q && !i_stall && (ready_pc_q == i_pc);

	assign o_ready = delivered;
	assign o_rdata = rdata_q;
	assign o_bus_request = request_q;
	assign o_bus_address = address_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
			request_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (request_q) begin
			ready_q <= 1'b0;
			if (i_bus_ready) begin
				line_valid[refill_index] <= 1'b1;
				request_q <= 1'b0;
				// Forward the refilled word directly
				ready_q <= 1'b1;
			end
		end else begin
			// Skip one lookup after a delivery so a word is never sent twice
			ready_q <= lookup_hit && !i_stall && !delivered;
			request_q <= !lookup_hit && !i_stall;
		end
	end

	// Line contents and lookup result
	always_ff @(posedge i_clock) begin
		if (request_q) begin
			if (i_bus_ready) begin
				line_tag[refill_index] <= refill_tag;
				line_data[refill_index] <= i_bus_rdata;
				rdata_q <= i_bus_rdata;
				ready_pc_q <= address_q;
			end
		end else begin
			rdata_q <= line_data[lookup_index];
			ready_pc_q <= i_pc;
			// Held while the request is up
			address_q <= {i_pc[31:2], 2'b00};
		end
	end

endmodule

// File: src/instr_predecode.sv
`timescale 1ns/1ps

module instr_predecode (
	input  rv_isa_pkg::rv_instr_u               i_instruction,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_rs1,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_rs2,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_rs3,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_rd,
	output logic                                o_control_flow
);

	logic [6:0] opcode;
	logic is_r, is_i, is_s, is_b, is_u, is_j, is_r4;
	logic fp_all;
	logic is_privileged;

	assign opcode = i_instruction.r.opcode;

	// Instruction formats
	always_comb begin
		is_r = (opcode == rv_isa_pkg::OPC_OP) || (opcode == rv_isa_pkg::OPC_OP_FP);
		is_i = (opcode == rv_isa_pkg::OPC_LOAD) || (opcode == rv_isa_pkg::OPC_OP_IMM) ||
			(opcode == rv_isa_pkg::OPC_JALR) || (opcode == rv_isa_pkg::OPC_LOAD_FP) ||
			(opcode == rv_isa_pkg::OPC_SYSTEM);
		is_s = (opcode == rv_isa_pkg::OPC_STORE) || (opcode == rv_isa_pkg::OPC_STORE_FP);
		is_b = (opcode == rv_isa_pkg::OPC_BRANCH);
		is_u = (opcode == rv_isa_pkg::OPC_LUI) || (opcode == rv_isa_pkg::OPC_AUIPC);
		is_j = (opcode == rv_isa_pkg::OPC_JAL);
		is_r4 = (opcode == rv_isa_pkg::OPC_FMADD);
	end

	// FP arithmetic uses the FP bank on every operand
	assign fp_all = (opcode == rv_isa_pkg::OPC_OP_FP) || is_r4;

	// Indices, zero where the format has no such register
	assign o_rs1 = (is_r || is_i || is_s || is_b || is_r4) ?
		{fp_all, i_instruction.r.rs1} : '0;
	assign o_rs2 = (is_r || is_s || is_b || is_r4) ?
		{fp_all || (opcode == rv_isa_pkg::OPC_STORE_FP), i_instruction.r.rs2} : '0;
	assign o_rs3 = is_r4 ? {fp_all, i_instruction.r.rs3} : '0;
	assign o_rd = (is_r || is_i || is_u || is_j || is_r4) ?
		{fp_all || (opcode == rv_isa_pkg::OPC_LOAD_FP), i_instruction.r.rd} : '0;

	// ECALL, MRET, WFI; CSR accesses share the opcode but have funct3 != 0
	assign is_privileged = (opcode == rv_isa_pkg::OPC_SYSTEM) &&
		(i_instruction.sys.funct3 == 3'b000) &&
		((i_instruction.sys.funct12 == rv_isa_pkg::F12_ECALL) ||
		(i_instruction.sys.funct12 == rv_isa_pkg::F12_MRET) ||
		(i_instruction.sys.funct12 == rv_isa_pkg::F12_WFI));

	assign o_control_flow = is_j || is_b || (opcode == rv_isa_pkg::OPC_JALR) || is_privileged;

endmodule

// File: src/fetch_sequencer.sv
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_sequencer (
	input  logic                                i_clock,
	input  logic                                i_reset,
	input  logic                                i_jump,
	input  logic [31:0]                         i_jump_pc,
	input  logic                                i_irq_pending,
	input  logic [31:0]                         i_irq_pc,
	input  logic                                i_decode_busy,
	input  logic                                i_cache_ready,
	input  logic [31:0]                         i_cache_rdata,
	input  logic [fetch_pkg::REG_INDEX_W-1:0]   i_rs1,
	input  logic [fetch_pkg::REG_INDEX_W-1:0]   i_rs2,
	input  logic [fetch_pkg::REG_INDEX_W-1:0]   i_rs3,
	input  logic [fetch_pkg::REG_INDEX_W-1:0]   i_rd,
	input  logic                                i_control_flow,
	output logic [31:0]                         o_pc,
	output logic                                o_cache_stall,
	output logic                                o_irq_dispatched,
	output logic [31:0]                         o_irq_epc,
	output logic [fetch_pkg::FETCH_TAG_W-1:0]   o_fetch_tag,
	output logic [31:0]                         o_fetch_instruction,
	output logic [31:0]                         o_fetch_pc,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs1,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs2,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs3,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rd
);

	logic state;
	logic [31:0] pc;
	logic irq_take;
	logic accept;

	// One cycle gap between dispatches lets execute drop its request
	assign irq_take = i_irq_pending && !o_irq_dispatched;
	assign accept = !irq_take && (state == fetch_pkg::ST_WAIT_CACHE) && i_cache_ready;

	assign o_pc = pc;
	assign o_cache_stall = i_decode_busy || (state == fetch_pkg::ST_WAIT_JUMP);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::ST_WAIT_CACHE;
			pc <= `FETCH_RESET_VECTOR;
			o_fetch_tag <= '0;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_irq_dispatched <= irq_take;
			if (irq_take) begin
				pc <= i_irq_pc;
				state <= fetch_pkg::ST_WAIT_CACHE;
			end else if (state == fetch_pkg::ST_WAIT_JUMP) begin
				if (i_jump) begin
					pc <= i_jump_pc;
					state <= fetch_pkg::ST_WAIT_CACHE;
				end
			end else if (accept) begin
				o_fetch_tag <= o_fetch_tag + 1'b1;
				// Execute decides where control flow goes next
				if (i_control_flow)
					state <= fetch_pkg::ST_WAIT_JUMP;
				else
					pc <= pc + 32'd4;
			end
		end
	end

	// Packet and interrupt return address
	always_ff @(posedge i_clock) begin
		if (irq_take)
			o_irq_epc <= pc;
		if (accept) begin
			o_fetch_instruction <= i_cache_rdata;
			o_fetch_pc <= pc;
			o_fetch_rs1 <= i_rs1;
			o_fetch_rs2 <= i_rs2;
			o_fetch_rs3 <= i_rs3;
			o_fetch_rd <= i_rd;
		end
	end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                                i_clock,
	input  logic                                i_reset,
	input  logic                                i_jump,
	input  logic [31:0]                         i_jump_pc,
	input  logic                                i_irq_pending,
	input  logic [31:0]                         i_irq_pc,
	output logic                                o_irq_dispatched,
	output logic [31:0]                         o_irq_epc,
	output logic                                o_bus_request,
	output logic [31:0]                         o_bus_address,
	input  logic                                i_bus_ready,
	input  logic [31:0]                         i_bus_rdata,
	input  logic                                i_decode_busy,
	output logic [fetch_pkg::FETCH_TAG_W-1:0]   o_fetch_tag,
	output logic [31:0]                         o_fetch_instruction,
	output logic [31:0]                         o_fetch_pc,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs1,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs2,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rs3,
	output logic [fetch_pkg::REG_INDEX_W-1:0]   o_fetch_rd
);

	logic [31:0] pc;
	logic cache_stall;
	logic cache_ready;
	logic [31:0] cache_rdata;
	logic [fetch_pkg::REG_INDEX_W-1:0] rs1, rs2, rs3, rd;
	logic control_flow;

	instr_cache u_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(cache_stall),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_rdata(cache_rdata),
		.o_ready(cache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address)
	);

	// Indices are ready in the same cycle as the cache word
	instr_predecode u_predecode (
		.i_instruction(cache_rdata),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rs3(rs3),
		.o_rd(rd),
		.o_control_flow(control_flow)
	);

	fetch_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.i_decode_busy(i_decode_busy),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_rs3(rs3),
		.i_rd(rd),
		.i_control_flow(control_flow),
		.o_pc(pc),
		.o_cache_stall(cache_stall),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_instruction(o_fetch_instruction),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_rs1(o_fetch_rs1),
		.o_fetch_rs2(o_fetch_rs2),
		.o_fetch_rs3(o_fetch_rs3),
		.o_fetch_rd(o_fetch_rd)
	);

endmodule

// File: testbench/fetch_unit_properties.sv
`timescale 1ns/1ps

module fetch_unit_properties (
	input logic                              i_clock,
	input logic                              i_reset,
	input logic                              o_bus_request,
	input logic [31:0]                       o_bus_address,
	input logic                              o_irq_dispatched,
	input logic [fetch_pkg::FETCH_TAG_W-1:0] o_fetch_tag
);

	// Address held until the memory answers
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request |=> (!o_bus_request || $stable(o_bus_address)))
	else $error("bus address changed during a pending request");

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
	else $error("interrupt dispatch lasted two cycles");

	// One packet per step
	assert property (@(posedge i_clock) disable iff (i_reset)
		!$stable(o_fetch_tag) |-> (o_fetch_tag == $past(o_fetch_tag) + 1))
	else $error("fetch tag skipped a value");

endmodule

bind fetch_unit fetch_unit_properties u_properties (.*);

// File: testbench/fetch_unit_tb.sv
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_unit_tb;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready = 1'b0;
	logic [31:0] i_bus_rdata = 32'h0;
	logic i_decode_busy;
	logic [fetch_pkg::FETCH_TAG_W-1:0] o_fetch_tag;
	logic [31:0] o_fetch_instruction;
	logic [31:0] o_fetch_pc;
	logic [fetch_pkg::REG_INDEX_W-1:0] o_fetch_rs1, o_fetch_rs2, o_fetch_rs3, o_fetch_rd;

	logic [31:0] mem [0:1023];
	integer seed = 33;
	integer bus_delay = 0;
	logic bus_active = 1'b0;
	integer value_errors = 0;
	integer timeout_errors = 0;
	logic [31:0] last_tag;

	fetch_unit DUT (.*);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// Memory answers each request after 1 to 3 cycles
	always @(negedge i_clock) begin
		if (i_bus_ready || i_reset || !o_bus_request) begin
			i_bus_ready = 1'b0;
			bus_active = 1'b0;
		end else begin
			if (!bus_active) begin
				bus_active = 1'b1;
				bus_delay = $unsigned($random(seed)) % 3;
			end
			if (bus_delay == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = mem[o_bus_address[11:2]];
			end else begin
				bus_delay = bus_delay - 1;
			end
		end
	end

	task automatic check_word(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %h expected %h", $time, name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [fetch_pkg::REG_INDEX_W-1:0] actual,
		input logic [fetch_pkg::REG_INDEX_W-1:0] expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %h expected %h", $time, name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %b expected %b", $time, name, actual, expected);
			value_errors++;
		end
	endtask

	// Register view with fixed fields, rs3=7 rs2=3 rs1=5 rd=9
	function automatic logic [31:0] make_word(input logic [6:0] opcode);
		rv_isa_pkg::rv_instr_u word;
		word.r.rs3 = 5'd7;
		word.r.format = 2'b00;
		word.r.rs2 = 5'd3;
		word.r.rs1 = 5'd5;
		word.r.funct3 = 3'b000;
		word.r.rd = 5'd9;
		word.r.opcode = opcode;
		return word;
	endfunction

	function automatic logic [31:0] make_system(input logic [11:0] funct12);
		rv_isa_pkg::rv_instr_u word;
		word.sys.funct12 = funct12;
		word.sys.rs1 = 5'd0;
		word.sys.funct3 = 3'b000;
		word.sys.rd = 5'd0;
		word.sys.opcode = rv_isa_pkg::OPC_SYSTEM;
		return word;
	endfunction

	task automatic load_program();
		logic [9:0] index;
		for (int i = 0; i < 1024; i++) begin
			index = i[9:0];
			// ADDI with immediate and rd taken from the word address
			mem[i] = {2'b00, index, 5'd0, 3'b000, index[4:0], rv_isa_pkg::OPC_OP_IMM};
		end
		mem[32'h210 >> 2] = make_word(rv_isa_pkg::OPC_JAL);
		mem[32'h400 >> 2] = make_word(rv_isa_pkg::OPC_OP);
		mem[32'h404 >> 2] = make_word(rv_isa_pkg::OPC_LOAD);
		mem[32'h408 >> 2] = make_word(rv_isa_pkg::OPC_STORE);
		mem[32'h40C >> 2] = make_word(rv_isa_pkg::OPC_LUI);
		mem[32'h410 >> 2] = make_word(rv_isa_pkg::OPC_FMADD);
		mem[32'h414 >> 2] = make_word(rv_isa_pkg::OPC_LOAD_FP);
		mem[32'h418 >> 2] = make_word(rv_isa_pkg::OPC_STORE_FP);
		mem[32'h41C >> 2] = make_word(rv_isa_pkg::OPC_OP_FP);
		mem[32'h420 >> 2] = make_word(rv_isa_pkg::OPC_BRANCH);
		mem[32'h600 >> 2] = make_system(rv_isa_pkg::F12_ECALL);
		mem[32'hA04 >> 2] = make_word(rv_isa_pkg::OPC_JAL);
	endtask

	// Waits for the next tag, optionally flags any bus request on the way
	task automatic next_packet(input logic [31:0] pc, input logic forbid_bus);
		int count;
		logic bus_seen;
		logic [31:0] bus_address;
		count = 0;
		bus_seen = 1'b0;
		bus_address = 32'h0;
		@(negedge i_clock);
		while (o_fetch_tag == last_tag && count < 50) begin
			if (o_bus_request) begin
				bus_seen = 1'b1;
				bus_address = o_bus_address;
			end
			count++;
			@(negedge i_clock);
		end
		if (count >= 50) begin
			$display("Timeout: no packet arrived after tag %0d", last_tag);
			timeout_errors++;
		end
		if (forbid_bus)
			check_bit("o_bus_request", bus_seen, 1'b0);
		else if (bus_seen)
			// The last refill before a packet fetches that packet's word
			check_word("o_bus_address", bus_address, pc);
		check_word("o_fetch_tag", o_fetch_tag, last_tag + 1);
		last_tag = o_fetch_tag;
	endtask

	task automatic check_packet(input logic [31:0] pc, input logic forbid_bus);
		next_packet(pc, forbid_bus);
		check_word("o_fetch_pc", o_fetch_pc, pc);
		check_word("o_fetch_instruction", o_fetch_instruction, mem[pc[11:2]]);
	endtask

	task automatic check_indices(input logic [fetch_pkg::REG_INDEX_W-1:0] rs1,
		input logic [fetch_pkg::REG_INDEX_W-1:0] rs2,
		input logic [fetch_pkg::REG_INDEX_W-1:0] rs3,
		input logic [fetch_pkg::REG_INDEX_W-1:0] rd);
		check_reg("o_fetch_rs1", o_fetch_rs1, rs1);
		check_reg("o_fetch_rs2", o_fetch_rs2, rs2);
		check_reg("o_fetch_rs3", o_fetch_rs3, rs3);
		check_reg("o_fetch_rd", o_fetch_rd, rd);
	endtask

	task automatic expect_no_packet(input int cycles);
		repeat (cycles) begin
			@(negedge i_clock);
			check_word("o_fetch_tag", o_fetch_tag, last_tag);
		end
	endtask

	task automatic jump_to(input logic [31:0] pc);
		i_jump = 1'b1;
		i_jump_pc = pc;
		@(negedge i_clock);
		i_jump = 1'b0;
	endtask

	task automatic test_sequential_fetch();
		for (int k = 0; k < 4; k++)
			check_packet(`FETCH_RESET_VECTOR + 4 * k, 1'b0);
		check_packet(32'h210, 1'b0);
	endtask

	task automatic test_control_flow();
		// Stopped after JAL
		expect_no_packet(10);
		jump_to(32'h600);
		check_packet(32'h600, 1'b0);
		expect_no_packet(10);
		jump_to(32'h400);
	endtask

	task automatic test_register_predecode();
		check_packet(32'h400, 1'b0);
		check_indices(6'd5, 6'd3, 6'd0, 6'd9);
		check_packet(32'h404, 1'b0);
		check_indices(6'd5, 6'd0, 6'd0, 6'd9);
		check_packet(32'h408, 1'b0);
		check_indices(6'd5, 6'd3, 6'd0, 6'd0);
		check_packet(32'h40C, 1'b0);
		check_indices(6'd0, 6'd0, 6'd0, 6'd9);
		check_packet(32'h410, 1'b0);
		check_indices(6'h25, 6'h23, 6'h27, 6'h29);
		check_packet(32'h414, 1'b0);
		check_indices(6'd5, 6'd0, 6'd0, 6'h29);
		check_packet(32'h418, 1'b0);
		check_indices(6'd5, 6'h23, 6'd0, 6'd0);
		check_packet(32'h41C, 1'b0);
		check_indices(6'h25, 6'h23, 6'd0, 6'h29);
		check_packet(32'h420, 1'b0);
		check_indices(6'd5, 6'd3, 6'd0, 6'd0);
		// The branch waits for execute
		expect_no_packet(8);
		jump_to(32'h800);
	endtask

	task automatic test_interrupt();
		int count;
		check_packet(32'h800, 1'b0);
		i_irq_pending = 1'b1;
		i_irq_pc = 32'hA00;
		@(negedge i_clock);
		i_irq_pending = 1'b0;
		count = 0;
		while (!o_irq_dispatched && count < 10) begin
			count++;
			@(negedge i_clock);
		end
		if (count >= 10) begin
			$display("Timeout: interrupt was never dispatched");
			timeout_errors++;
		end
		// Fetch had moved on to the word after 0x800
		check_word("o_irq_epc", o_irq_epc, 32'h804);
		check_packet(32'hA00, 1'b0);
		check_packet(32'hA04, 1'b0);
	endtask

	task automatic test_cache_hit();
		jump_to(32'hA00);
		check_packet(32'hA00, 1'b1);
		check_packet(32'hA04, 1'b1);
	endtask

	task automatic test_back_pressure();
		logic [31:0] held_pc;
		logic [31:0] held_instruction;
		jump_to(32'hC00);
		check_packet(32'hC00, 1'b0);
		i_decode_busy = 1'b1;
		held_pc = o_fetch_pc;
		held_instruction = o_fetch_instruction;
		repeat (12) begin
			@(negedge i_clock);
			check_word("o_fetch_tag", o_fetch_tag, last_tag);
			check_word("o_fetch_pc", o_fetch_pc, held_pc);
			check_word("o_fetch_instruction", o_fetch_instruction, held_instruction);
		end
		i_decode_busy = 1'b0;
		check_packet(32'hC04, 1'b0);
	endtask

	initial begin
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = 32'h0;
		i_irq_pending = 1'b0;
		i_irq_pc = 32'h0;
		i_decode_busy = 1'b0;
		last_tag = 32'h0;
		load_program();
		repeat (2) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		check_word("o_fetch_tag", o_fetch_tag, 32'h0);
		check_bit("o_irq_dispatched", o_irq_dispatched, 1'b0);
		check_bit("o_bus_request", o_bus_request, 1'b0);
		test_sequential_fetch();
		test_control_flow();
		test_register_predecode();
		test_interrupt();
		test_cache_hit();
		test_back_pressure();
		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
src/rv_isa_pkg.sv
src/fetch_pkg.sv
src/instr_cache.sv
src/instr_predecode.sv
src/fetch_sequencer.sv
src/fetch_unit.sv
testbench/fetch_unit_properties.sv
testbench/fetch_unit_tb.sv

// File: Makefile
LOG = sim.log

all: run

build:
	verilator --binary --assert -f flist.f --top-module fetch_unit_tb -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)
	! grep -q "Result: FAILED" $(LOG)

lint:
	verilator --lint-only -Wall +incdir+include src/rv_isa_pkg.sv src/fetch_pkg.sv \
		src/instr_cache.sv src/instr_predecode.sv src/fetch_sequencer.sv src/fetch_unit.sv \
		--top-module fetch_unit

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
